/* rtl/udp_echo_pkg.sv */
package udp_echo_pkg;

    // UDP destination port that is looped back to the sender
    localparam logic [15:0] ECHO_PORT = 16'd1234;

    // Address of this node, 192.168.1.128
    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    // Time-to-live placed in every reply
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // Payload FIFO holds 2**FIFO_ADDR_WIDTH bytes
    localparam int FIFO_ADDR_WIDTH = 4;

    // Decoded UDP header, same layout for receive and reply
    typedef struct packed {
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [15:0] checksum;
    } udp_hdr_t;

    // One payload byte on a byte stream
    typedef struct packed {
        logic [7:0] data;
        // End of frame
        logic       last;
        // Bad-frame flag carried along from the receiver
        logic       user;
    } axis_byte_t;

    // Per-frame decision of the port filter
    typedef enum logic [1:0] {
        FILTER_IDLE,
        FILTER_FORWARD,
        FILTER_DISCARD
    } filter_state_t;

endpackage

/* rtl/udp_port_filter.sv */
module udp_port_filter (
    input  logic                     clk,
    input  logic                     rst,

    // Incoming decoded header
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t   rx_hdr,

    // Incoming payload
    input  logic                     rx_payload_valid,
    output logic                     rx_payload_ready,
    input  udp_echo_pkg::axis_byte_t rx_payload,

    // Reply header
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_echo_pkg::udp_hdr_t   tx_hdr,

    // Payload toward the FIFO
    output logic                     fifo_in_valid,
    input  logic                     fifo_in_ready,
    output udp_echo_pkg::axis_byte_t fifo_in
);
    import udp_echo_pkg::*;

    filter_state_t state;
    filter_state_t state_next;
    logic          port_match;
    logic          hdr_xfer;
    logic          payload_end;

    assign port_match = (rx_hdr.dest_port == ECHO_PORT);

    // Header side, only open between frames
    always_comb begin
        rx_hdr_ready = 1'b0;
        tx_hdr_valid = 1'b0;
        if (state == FILTER_IDLE && rx_hdr_valid) begin
            if (port_match) begin
                // Both header transfers happen in the same cycle
                tx_hdr_valid = 1'b1;
                rx_hdr_ready = tx_hdr_ready;
            end else begin
                rx_hdr_ready = 1'b1;
            end
        end
    end

    // Reply header with addresses and ports swapped
    always_comb begin
        tx_hdr.source_ip   = LOCAL_IP;
        tx_hdr.dest_ip     = rx_hdr.source_ip;
        tx_hdr.source_port = rx_hdr.dest_port;
        tx_hdr.dest_port   = rx_hdr.source_port;
        tx_hdr.length      = rx_hdr.length;
        tx_hdr.ttl         = REPLY_TTL;
        tx_hdr.checksum    = 16'd0;
    end

    // Payload steering
    always_comb begin
        case (state)
            FILTER_FORWARD: rx_payload_ready = fifo_in_ready;
            FILTER_DISCARD: rx_payload_ready = 1'b1;
            default:        rx_payload_ready = 1'b0;
        endcase
    end

    assign fifo_in_valid = (state == FILTER_FORWARD) && rx_payload_valid;
    assign fifo_in       = rx_payload;

    assign hdr_xfer    = rx_hdr_valid && rx_hdr_ready;
    assign payload_end = rx_payload_valid && rx_payload_ready && rx_payload.last;

    // Decision is taken once, at the header transfer
    always_comb begin
        state_next = state;
        case (state)
            FILTER_IDLE: begin
                if (hdr_xfer) begin
                    state_next = port_match ? FILTER_FORWARD : FILTER_DISCARD;
                end
            end
            FILTER_FORWARD, FILTER_DISCARD: begin
                if (payload_end) begin
                    state_next = FILTER_IDLE;
                end
            end
            default: state_next = FILTER_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILTER_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* rtl/payload_fifo.sv */
module payload_fifo (
    input  logic                     clk,
    input  logic                     rst,

    // Write side
    input  logic                     in_valid,
    output logic                     in_ready,
    input  udp_echo_pkg::axis_byte_t in_byte,

    // Read side
    output logic                     out_valid,
    input  logic                     out_ready,
    output udp_echo_pkg::axis_byte_t out_byte
);
    import udp_echo_pkg::*;

    axis_byte_t mem [2**FIFO_ADDR_WIDTH];

    // Extra top bit tells full from empty
    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                   (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_byte  = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= in_byte;
        end
    end

    // Pointers
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* rtl/led_first_byte.sv */
module led_first_byte (
    input  logic                     clk,
    input  logic                     rst,

    // Observed transmit stream
    input  logic                     byte_valid,
    input  logic                     byte_ready,
    input  udp_echo_pkg::axis_byte_t byte_in,

    output logic [7:0]               led
);

    logic in_frame;
    logic xfer;

    assign xfer = byte_valid && byte_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= 8'd0;
        end else if (xfer) begin
            // First byte of a frame goes to the LEDs
            if (!in_frame) begin
                led <= byte_in.data;
            end
            in_frame <= !byte_in.last;
        end
    end

endmodule

/* rtl/udp_echo_core.sv */
module udp_echo_core (
    input  logic                     clk,
    input  logic                     rst,

    // Receive header and payload
    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t   rx_hdr,
    input  logic                     rx_payload_valid,
    output logic                     rx_payload_ready,
    input  udp_echo_pkg::axis_byte_t rx_payload,

    // Transmit header and payload
    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_echo_pkg::udp_hdr_t   tx_hdr,
    output logic                     tx_payload_valid,
    input  logic                     tx_payload_ready,
    output udp_echo_pkg::axis_byte_t tx_payload,

    output logic [7:0]               led
);
    import udp_echo_pkg::*;

    // Filter to FIFO
    logic       fifo_in_valid;
    logic       fifo_in_ready;
    axis_byte_t fifo_in;

    udp_port_filter u_filter (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_hdr           (rx_hdr),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload       (rx_payload),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_hdr           (tx_hdr),
        .fifo_in_valid    (fifo_in_valid),
        .fifo_in_ready    (fifo_in_ready),
        .fifo_in          (fifo_in)
    );

    payload_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fifo_in_valid),
        .in_ready  (fifo_in_ready),
        .in_byte   (fifo_in),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready),
        .out_byte  (tx_payload)
    );

    // Watches the transmit stream only
    led_first_byte u_led (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (tx_payload_valid),
        .byte_ready (tx_payload_ready),
        .byte_in    (tx_payload),
        .led        (led)
    );

endmodule

/* bench/udp_echo_checker.sv */
module udp_echo_checker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t   tx_hdr,
    input  logic                     tx_payload_valid,
    input  logic                     tx_payload_ready,
    input  udp_echo_pkg::axis_byte_t tx_payload,
    input  logic [7:0]               led
);
    import udp_echo_pkg::*;

    // Reply header held until the sink takes it
    hdr_held: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else $error("tx_hdr dropped or changed before tx_hdr_ready");

    // Same rule on the payload stream out of the FIFO
    payload_held: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid && $stable(tx_payload))
        else $error("tx_payload dropped or changed before tx_payload_ready");

    // Fixed reply fields
    hdr_fields: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid |-> tx_hdr.source_ip == LOCAL_IP && tx_hdr.ttl == REPLY_TTL)
        else $error("tx_hdr source_ip or ttl wrong");

    reset_state: assert property (@(posedge clk)
        rst |=> led == 8'd0 && !tx_payload_valid)
        else $error("led or tx_payload_valid not cleared by reset");

endmodule

bind udp_echo_core udp_echo_checker u_checker (
    .clk              (clk),
    .rst              (rst),
    .tx_hdr_valid     (tx_hdr_valid),
    .tx_hdr_ready     (tx_hdr_ready),
    .tx_hdr           (tx_hdr),
    .tx_payload_valid (tx_payload_valid),
    .tx_payload_ready (tx_payload_ready),
    .tx_payload       (tx_payload),
    .led              (led)
);

/* bench/udp_echo_core_tb.sv */
module udp_echo_core_tb;
    import udp_echo_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 10;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_FRAMES      = 8;
    localparam int CYCLES_PER_BYTE = 20;
    localparam int FIFO_DEPTH      = 2**FIFO_ADDR_WIDTH;

    // One row of the frame table
    typedef struct packed {
        logic [15:0] dest_port;
        logic [15:0] source_port;
        logic [31:0] source_ip;
        logic [15:0] length;
        logic [7:0]  first_byte;
        logic        echo;
    } frame_t;

    logic       clk;
    logic       rst;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    udp_hdr_t   rx_hdr;
    logic       rx_payload_valid;
    logic       rx_payload_ready;
    axis_byte_t rx_payload;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready;
    udp_hdr_t   tx_hdr;
    logic       tx_payload_valid;
    logic       tx_payload_ready;
    axis_byte_t tx_payload;
    logic [7:0] led;

    frame_t      frames [NUM_FRAMES];
    udp_hdr_t    hdr_q [$];
    axis_byte_t  payload_q [$];
    udp_hdr_t    exp_hdr;
    axis_byte_t  exp_byte;
    logic [7:0]  exp_led;
    logic        tx_in_frame;
    logic [31:0] rand_bits;
    integer      seed = 32'h18e0_d3fe;
    int          mismatch_count;
    int          other_errors;
    int          echoed_expected;
    int          echoed_seen;

    udp_echo_core u_dut (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_hdr           (rx_hdr),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload       (rx_payload),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_hdr           (tx_hdr),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload       (tx_payload),
        .led              (led)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic frame_t make_frame(input logic [15:0] dest_port,
                                          input logic [15:0] source_port,
                                          input logic [31:0] source_ip,
                                          input int len,
                                          input logic [7:0] first_byte,
                                          input logic echo);
        frame_t f;
        f.dest_port   = dest_port;
        f.source_port = source_port;
        f.source_ip   = source_ip;
        f.length      = 16'(len);
        f.first_byte  = first_byte;
        f.echo        = echo;
        return f;
    endfunction

    task automatic load_frames();
        frames[0] = make_frame(ECHO_PORT, 16'd5000, {8'd192, 8'd168, 8'd1, 8'd20}, 4, 8'h10, 1'b1);
        frames[1] = make_frame(16'd80, 16'd5001, {8'd192, 8'd168, 8'd1, 8'd21}, 3, 8'h20, 1'b0);
        frames[2] = make_frame(ECHO_PORT, 16'd5002, {8'd10, 8'd0, 8'd0, 8'd7}, 1, 8'ha5, 1'b1);
        // Longer than the FIFO so the receive side stalls
        frames[3] = make_frame(ECHO_PORT, 16'd5003, {8'd10, 8'd0, 8'd0, 8'd8},
                               2 * FIFO_DEPTH + 8, 8'h30, 1'b1);
        // Echo port with its bytes swapped
        frames[4] = make_frame(16'hd204, 16'd5004, {8'd10, 8'd0, 8'd0, 8'd9}, 5, 8'h77, 1'b0);
        frames[5] = make_frame(ECHO_PORT, 16'd5005, {8'd172, 8'd16, 8'd0, 8'd3}, 20, 8'hc0, 1'b1);
        frames[6] = make_frame(ECHO_PORT + 16'd1, 16'd5006, {8'd172, 8'd16, 8'd0, 8'd4}, 2,
                               8'h55, 1'b0);
        // Byte counter wraps past 8'hff
        frames[7] = make_frame(ECHO_PORT, 16'd6000, {8'd192, 8'd168, 8'd1, 8'd99}, 6, 8'hfc, 1'b1);
    endtask

    task automatic report_mismatch(input string name, input logic [135:0] expected,
                                   input logic [135:0] actual);
        $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        mismatch_count++;
    endtask

    // Reply header and payload built from the echo rules
    task automatic expect_echo(input frame_t f);
        udp_hdr_t   h;
        axis_byte_t b;
        int         len;
        len           = int'(f.length);
        h.source_ip   = LOCAL_IP;
        h.dest_ip     = f.source_ip;
        h.source_port = f.dest_port;
        h.dest_port   = f.source_port;
        h.length      = f.length + 16'd8;
        h.ttl         = REPLY_TTL;
        h.checksum    = 16'd0;
        hdr_q.push_back(h);
        for (int i = 0; i < len; i++) begin
            b.data = f.first_byte + 8'(i);
            b.last = (i == len - 1);
            b.user = 1'b0;
            payload_q.push_back(b);
        end
        echoed_expected++;
    endtask

    // Ready is sampled mid-cycle, the transfer is at the next rising edge
    task automatic wait_transfer(input logic is_hdr);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = is_hdr ? rx_hdr_ready : rx_payload_ready;
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic send_frame(input frame_t f);
        int len;
        len                = int'(f.length);
        rx_hdr.source_ip   = f.source_ip;
        rx_hdr.dest_ip     = LOCAL_IP;
        rx_hdr.source_port = f.source_port;
        rx_hdr.dest_port   = f.dest_port;
        rx_hdr.length      = f.length + 16'd8;
        rx_hdr.ttl         = 8'd31;
        rx_hdr.checksum    = 16'hbeef;
        rx_hdr_valid       = 1'b1;
        wait_transfer(1'b1);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            rx_payload.data  = f.first_byte + 8'(i);
            rx_payload.last  = (i == len - 1);
            rx_payload.user  = 1'b0;
            rx_payload_valid = 1'b1;
            wait_transfer(1'b0);
        end
        rx_payload_valid = 1'b0;
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Random back-pressure on both tx readies
    initial begin
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            rand_bits        = $random(seed);
            tx_hdr_ready     = rand_bits[0];
            tx_payload_ready = rand_bits[1];
        end
    end

    // Scoreboard, sampled mid-cycle where all outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            if (tx_hdr_valid !== 1'b0) begin
                report_mismatch("tx_hdr_valid", 136'd0, 136'(tx_hdr_valid));
            end
            if (tx_payload_valid !== 1'b0) begin
                report_mismatch("tx_payload_valid", 136'd0, 136'(tx_payload_valid));
            end
            if (rx_hdr_ready !== 1'b0) begin
                report_mismatch("rx_hdr_ready", 136'd0, 136'(rx_hdr_ready));
            end
            if (rx_payload_ready !== 1'b0) begin
                report_mismatch("rx_payload_ready", 136'd0, 136'(rx_payload_ready));
            end
            if (led !== 8'd0) begin
                report_mismatch("led", 136'd0, 136'(led));
            end
        end else begin
            if (led !== exp_led) begin
                report_mismatch("led", 136'(exp_led), 136'(led));
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    $display("error at %0t: tx header sent with none expected", $time);
                    other_errors++;
                end else begin
                    exp_hdr = hdr_q.pop_front();
                    if (tx_hdr !== exp_hdr) begin
                        report_mismatch("tx_hdr", 136'(exp_hdr), 136'(tx_hdr));
                    end
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (payload_q.size() == 0) begin
                    $display("error at %0t: tx payload byte sent with none expected", $time);
                    other_errors++;
                end else begin
                    exp_byte = payload_q.pop_front();
                    if (tx_payload !== exp_byte) begin
                        report_mismatch("tx_payload", 136'(exp_byte), 136'(tx_payload));
                    end
                    // LEDs follow the first byte of each frame
                    if (!tx_in_frame) begin
                        exp_led = exp_byte.data;
                    end
                    tx_in_frame = !exp_byte.last;
                    if (tx_payload.last) begin
                        echoed_seen++;
                    end
                end
            end
        end
    end

    initial begin
        load_frames();
        mismatch_count   = 0;
        other_errors     = 0;
        echoed_expected  = 0;
        echoed_seen      = 0;
        exp_led          = 8'd0;
        tx_in_frame      = 1'b0;
        rst              = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_hdr           = '0;
        rx_payload_valid = 1'b0;
        rx_payload       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        for (int k = 0; k < NUM_FRAMES; k++) begin
            if (frames[k].echo) begin
                expect_echo(frames[k]);
            end
            send_frame(frames[k]);
        end
        // Drain the FIFO, then watch a while for stray output
        while (payload_q.size() != 0 || hdr_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (FIFO_DEPTH) @(posedge clk);
        if (echoed_seen != echoed_expected) begin
            report_mismatch("echoed_frames", 136'(echoed_expected), 136'(echoed_seen));
        end
        finish_run();
    end

    // Watchdog scaled by the table's total byte count
    initial begin
        int total_bytes;
        total_bytes = 0;
        #1;
        for (int k = 0; k < NUM_FRAMES; k++) begin
            total_bytes += int'(frames[k].length);
        end
        #((RESET_CYCLES + total_bytes * CYCLES_PER_BYTE) * CLK_PERIOD);
        $display("timeout at %0t: frames did not complete in time", $time);
        other_errors++;
        finish_run();
    end

endmodule

/* udp_echo_core.f */
rtl/udp_echo_pkg.sv
rtl/udp_port_filter.sv
rtl/payload_fifo.sv
rtl/led_first_byte.sv
rtl/udp_echo_core.sv
bench/udp_echo_checker.sv
bench/udp_echo_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module udp_echo_core_tb -f udp_echo_core.f -o udp_echo_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/udp_echo_sim > sim.log 2>&1
cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
